// File: hw/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [7:0] op_t;
    typedef logic [2:0] cat_t;

    localparam int SHAMT_W = 5;

    // Operator codes
    localparam op_t OP_NOP   = 8'b0000_0000;
    localparam op_t OP_AND   = 8'b0010_0100;
    localparam op_t OP_OR    = 8'b0010_0101;
    localparam op_t OP_XOR   = 8'b0010_0110;
    localparam op_t OP_NOR   = 8'b0010_0111;
    localparam op_t OP_SLL   = 8'b0111_1100;
    localparam op_t OP_SRL   = 8'b0000_0010;
    localparam op_t OP_SRA   = 8'b0000_0011;
    localparam op_t OP_ADD   = 8'b0010_0000;
    localparam op_t OP_ADDU  = 8'b0010_0001;
    localparam op_t OP_SUB   = 8'b0010_0010;
    localparam op_t OP_SUBU  = 8'b0010_0011;
    localparam op_t OP_SLT   = 8'b0010_1010;
    localparam op_t OP_SLTU  = 8'b0010_1011;
    localparam op_t OP_CLZ   = 8'b1011_0000;
    localparam op_t OP_CLO   = 8'b1011_0001;
    localparam op_t OP_MULT  = 8'b0001_1000;
    localparam op_t OP_MULTU = 8'b0001_1001;
    localparam op_t OP_MTHI  = 8'b0001_0001;
    localparam op_t OP_MTLO  = 8'b0001_0011;
    localparam op_t OP_MFHI  = 8'b0001_0000;
    localparam op_t OP_MFLO  = 8'b0001_0010;

    // Result categories
    localparam cat_t CAT_NONE  = 3'b000;
    localparam cat_t CAT_LOGIC = 3'b001;
    localparam cat_t CAT_SHIFT = 3'b010;
    localparam cat_t CAT_MOVE  = 3'b011;
    localparam cat_t CAT_ARITH = 3'b100;

endpackage

// File: hw/ex_types_pkg.sv
package ex_types_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [2*XLEN-1:0]     dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // General register write, as latched into EX/MEM
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } gpr_wr_t;

    // HI/LO write request
    typedef struct packed {
        logic  hi_we;
        word_t hi_data;
        logic  lo_we;
        word_t lo_data;
    } hilo_wr_t;

endpackage

// File: hw/ex_logic_shift.sv
`timescale 1ns/1ps

module ex_logic_shift
    import mips_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  op_t   operator_i,
    input  word_t operand_a_i,
    input  word_t operand_b_i,
    output word_t logic_o,
    output word_t shift_o
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = operand_a_i[SHAMT_W-1:0];

    always_comb begin
        case (operator_i)
            OP_AND: begin
                logic_o = operand_a_i & operand_b_i;
            end
            OP_OR: begin
                logic_o = operand_a_i | operand_b_i;
            end
            OP_XOR: begin
                logic_o = operand_a_i ^ operand_b_i;
            end
            OP_NOR: begin
                logic_o = ~(operand_a_i | operand_b_i);
            end
            default: begin
                logic_o = '0;
            end
        endcase
    end

    always_comb begin
        case (operator_i)
            OP_SLL: begin
                shift_o = operand_b_i << shamt;
            end
            OP_SRL: begin
                shift_o = operand_b_i >> shamt;
            end
            OP_SRA: begin
                // Sign fill from operand B
                shift_o = word_t'($signed(operand_b_i) >>> shamt);
            end
            default: begin
                shift_o = '0;
            end
        endcase
    end

endmodule

// File: hw/ex_arith.sv
`timescale 1ns/1ps

module ex_arith
    import mips_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  op_t    operator_i,
    input  word_t  operand_a_i,
    input  word_t  operand_b_i,
    output word_t  result_o,
    output dword_t product_o,
    output logic   ovf_o
);

    word_t                  b_eff;
    word_t                  sum;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [$clog2(XLEN):0]  lead_cnt;
    logic signed [2*XLEN-1:0] prod_s;
    dword_t                 prod_u;

    // Counts leading zeros from the MSB down
    function automatic logic [$clog2(XLEN):0] lead_zeros(word_t value);
        logic [$clog2(XLEN):0] count;
        logic                  done;
        count = '0;
        done  = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (!done && !value[i]) begin
                count = count + 1'b1;
            end else begin
                done = 1'b1;
            end
        end
        return count;
    endfunction

    // One adder, B negated for subtract and compare
    always_comb begin
        case (operator_i)
            OP_SUB, OP_SUBU, OP_SLT: begin
                b_eff = ~operand_b_i + 1'b1;
            end
            default: begin
                b_eff = operand_b_i;
            end
        endcase
    end

    assign sum = operand_a_i + b_eff;

    assign lt_signed = (operand_a_i[XLEN-1] && !operand_b_i[XLEN-1]) ||
                       ((operand_a_i[XLEN-1] == operand_b_i[XLEN-1]) && sum[XLEN-1]);
    assign lt_unsigned = operand_a_i < operand_b_i;

    // CLO is CLZ of the inverted operand
    assign lead_cnt = (operator_i == OP_CLO) ? lead_zeros(~operand_a_i)
                                             : lead_zeros(operand_a_i);

    assign prod_s = $signed(operand_a_i) * $signed(operand_b_i);
    assign prod_u = operand_a_i * operand_b_i;

    always_comb begin
        case (operator_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                result_o = sum;
            end
            OP_SLT: begin
                result_o = word_t'(lt_signed);
            end
            OP_SLTU: begin
                result_o = word_t'(lt_unsigned);
            end
            OP_CLZ, OP_CLO: begin
                result_o = word_t'(lead_cnt);
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    always_comb begin
        case (operator_i)
            OP_MULT: begin
                product_o = dword_t'(prod_s);
            end
            OP_MULTU: begin
                product_o = prod_u;
            end
            default: begin
                product_o = '0;
            end
        endcase
    end

    // Signed overflow, B sign taken after negation
    assign ovf_o = ((operator_i == OP_ADD) || (operator_i == OP_SUB)) &&
                   (operand_a_i[XLEN-1] == b_eff[XLEN-1]) &&
                   (sum[XLEN-1] != operand_a_i[XLEN-1]);

    always_comb begin
        assert (lead_cnt <= XLEN)
            else $error("leading-bit count %0d above word width", lead_cnt);
    end

endmodule

// File: hw/ex_hilo.sv
`timescale 1ns/1ps

module ex_hilo
    import mips_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  op_t    operator_i,
    input  word_t  operand_a_i,
    input  dword_t product_i,
    input  logic   mem_hi_we_i,
    input  word_t  mem_hi_wdata_i,
    input  logic   mem_lo_we_i,
    input  word_t  mem_lo_wdata_i,
    input  logic   wb_hi_we_i,
    input  word_t  wb_hi_wdata_i,
    input  logic   wb_lo_we_i,
    input  word_t  wb_lo_wdata_i,
    input  word_t  wb_hi_rdata_i,
    input  word_t  wb_lo_rdata_i,
    output word_t  move_o,
    output logic   hi_we_o,
    output word_t  hi_wdata_o,
    output logic   lo_we_o,
    output word_t  lo_wdata_o
);

    word_t hi_cur;
    word_t lo_cur;

    // Youngest pending write wins
    assign hi_cur = mem_hi_we_i ? mem_hi_wdata_i :
                    wb_hi_we_i  ? wb_hi_wdata_i  : wb_hi_rdata_i;
    assign lo_cur = mem_lo_we_i ? mem_lo_wdata_i :
                    wb_lo_we_i  ? wb_lo_wdata_i  : wb_lo_rdata_i;

    assign move_o = (operator_i == OP_MFHI) ? hi_cur :
                    (operator_i == OP_MFLO) ? lo_cur : '0;

    always_comb begin
        hi_we_o    = 1'b0;
        hi_wdata_o = '0;
        lo_we_o    = 1'b0;
        lo_wdata_o = '0;
        case (operator_i)
            OP_MTHI: begin
                hi_we_o    = 1'b1;
                hi_wdata_o = operand_a_i;
            end
            OP_MTLO: begin
                lo_we_o    = 1'b1;
                lo_wdata_o = operand_a_i;
            end
            OP_MULT, OP_MULTU: begin
                hi_we_o    = 1'b1;
                hi_wdata_o = product_i[2*XLEN-1:XLEN];
                lo_we_o    = 1'b1;
                lo_wdata_o = product_i[XLEN-1:0];
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (hi_we_o && !lo_we_o) begin
            assert (operator_i == OP_MTHI)
                else $error("HI-only write from operator %h", operator_i);
        end
    end

endmodule

// File: hw/ex_pipe_reg.sv
`timescale 1ns/1ps

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // EX/MEM latch, reloaded on every edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

    a_no_unknown: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(q_o)
    ) else $error("unknown bits in EX/MEM register");

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import mips_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  op_t       operator_i,
    input  cat_t      category_i,
    input  word_t     operand_a_i,
    input  word_t     operand_b_i,
    input  logic      reg_write_en_i,
    input  reg_addr_t reg_write_addr_i,
    input  logic      mem_hi_we_i,
    input  word_t     mem_hi_wdata_i,
    input  logic      mem_lo_we_i,
    input  word_t     mem_lo_wdata_i,
    input  logic      wb_hi_we_i,
    input  word_t     wb_hi_wdata_i,
    input  logic      wb_lo_we_i,
    input  word_t     wb_lo_wdata_i,
    input  word_t     wb_hi_rdata_i,
    input  word_t     wb_lo_rdata_i,
    output logic      reg_write_en_o,
    output reg_addr_t reg_write_addr_o,
    output word_t     reg_write_data_o,
    output logic      hi_write_en_o,
    output word_t     hi_write_data_o,
    output logic      lo_write_en_o,
    output word_t     lo_write_data_o
);

    word_t    logic_res;
    word_t    shift_res;
    word_t    arith_res;
    word_t    move_res;
    dword_t   product;
    logic     ovf;
    word_t    wr_data;
    logic     hi_we;
    word_t    hi_wdata;
    logic     lo_we;
    word_t    lo_wdata;
    gpr_wr_t  gpr_d;
    gpr_wr_t  gpr_q;
    hilo_wr_t hilo_d;
    hilo_wr_t hilo_q;

    ex_logic_shift u_logic_shift (
        .operator_i  (operator_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .logic_o     (logic_res),
        .shift_o     (shift_res)
    );

    ex_arith u_arith (
        .operator_i  (operator_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (arith_res),
        .product_o   (product),
        .ovf_o       (ovf)
    );

    ex_hilo u_hilo (
        .operator_i     (operator_i),
        .operand_a_i    (operand_a_i),
        .product_i      (product),
        .mem_hi_we_i    (mem_hi_we_i),
        .mem_hi_wdata_i (mem_hi_wdata_i),
        .mem_lo_we_i    (mem_lo_we_i),
        .mem_lo_wdata_i (mem_lo_wdata_i),
        .wb_hi_we_i     (wb_hi_we_i),
        .wb_hi_wdata_i  (wb_hi_wdata_i),
        .wb_lo_we_i     (wb_lo_we_i),
        .wb_lo_wdata_i  (wb_lo_wdata_i),
        .wb_hi_rdata_i  (wb_hi_rdata_i),
        .wb_lo_rdata_i  (wb_lo_rdata_i),
        .move_o         (move_res),
        .hi_we_o        (hi_we),
        .hi_wdata_o     (hi_wdata),
        .lo_we_o        (lo_we),
        .lo_wdata_o     (lo_wdata)
    );

    // Write data by category
    always_comb begin
        case (category_i)
            CAT_LOGIC: wr_data = logic_res;
            CAT_SHIFT: wr_data = shift_res;
            CAT_MOVE:  wr_data = move_res;
            CAT_ARITH: wr_data = arith_res;
            default:   wr_data = '0;
        endcase
    end

    // Overflow drops the register write
    assign gpr_d.we   = reg_write_en_i && !ovf;
    assign gpr_d.addr = reg_write_addr_i;
    assign gpr_d.data = wr_data;

    assign hilo_d.hi_we   = hi_we;
    assign hilo_d.hi_data = hi_wdata;
    assign hilo_d.lo_we   = lo_we;
    assign hilo_d.lo_data = lo_wdata;

    ex_pipe_reg #(.payload_t(gpr_wr_t)) u_gpr_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .d_i      (gpr_d),
        .q_o      (gpr_q)
    );

    ex_pipe_reg #(.payload_t(hilo_wr_t)) u_hilo_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .d_i      (hilo_d),
        .q_o      (hilo_q)
    );

    assign reg_write_en_o   = gpr_q.we;
    assign reg_write_addr_o = gpr_q.addr;
    assign reg_write_data_o = gpr_q.data;
    assign hi_write_en_o    = hilo_q.hi_we;
    assign hi_write_data_o  = hilo_q.hi_data;
    assign lo_write_en_o    = hilo_q.lo_we;
    assign lo_write_data_o  = hilo_q.lo_data;

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Released on a rising edge, so the flops still see reset on that edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage
    import mips_isa_pkg::*;
    import ex_types_pkg::*;
();

    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 10;
    localparam int NUM_RANDOM    = 300;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t reg_addr;
        word_t     reg_data;
        logic      hi_we;
        word_t     hi_data;
        logic      lo_we;
        word_t     lo_data;
    } exp_t;

    logic      clk;
    logic      arst_n;
    op_t       operator;
    cat_t      category;
    word_t     operand_a;
    word_t     operand_b;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    logic      mem_hi_we;
    word_t     mem_hi_wdata;
    logic      mem_lo_we;
    word_t     mem_lo_wdata;
    logic      wb_hi_we;
    word_t     wb_hi_wdata;
    logic      wb_lo_we;
    word_t     wb_lo_wdata;
    word_t     wb_hi_rdata;
    word_t     wb_lo_rdata;
    logic      reg_we_out;
    reg_addr_t reg_addr_out;
    word_t     reg_data_out;
    logic      hi_we_out;
    word_t     hi_data_out;
    logic      lo_we_out;
    word_t     lo_data_out;

    exp_t exp_q[$];
    int   errors = 0;

    op_t op_list[22] = '{OP_NOP, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
                         OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
                         OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO};
    word_t shamts[5] = '{32'd0, 32'd31, 32'd16, 32'hFFFF_FFE3, 32'd1};

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ex_stage dut (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .operator_i       (operator),
        .category_i       (category),
        .operand_a_i      (operand_a),
        .operand_b_i      (operand_b),
        .reg_write_en_i   (reg_write_en),
        .reg_write_addr_i (reg_write_addr),
        .mem_hi_we_i      (mem_hi_we),
        .mem_hi_wdata_i   (mem_hi_wdata),
        .mem_lo_we_i      (mem_lo_we),
        .mem_lo_wdata_i   (mem_lo_wdata),
        .wb_hi_we_i       (wb_hi_we),
        .wb_hi_wdata_i    (wb_hi_wdata),
        .wb_lo_we_i       (wb_lo_we),
        .wb_lo_wdata_i    (wb_lo_wdata),
        .wb_hi_rdata_i    (wb_hi_rdata),
        .wb_lo_rdata_i    (wb_lo_rdata),
        .reg_write_en_o   (reg_we_out),
        .reg_write_addr_o (reg_addr_out),
        .reg_write_data_o (reg_data_out),
        .hi_write_en_o    (hi_we_out),
        .hi_write_data_o  (hi_data_out),
        .lo_write_en_o    (lo_we_out),
        .lo_write_data_o  (lo_data_out)
    );

    task automatic fail_run(string why);
        errors++;
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    function automatic int lead_count(word_t w, logic bit_val);
        int n;
        n = 0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (w[i] != bit_val) begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    function automatic cat_t cat_of(op_t op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR: return CAT_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        return CAT_SHIFT;
            OP_MFHI, OP_MFLO:              return CAT_MOVE;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:
                return CAT_ARITH;
            default:                       return CAT_NONE;
        endcase
    endfunction

    // Expected EX/MEM contents; forwarding inputs are read as currently driven
    function automatic exp_t ref_ex(op_t op, cat_t cat, word_t a, word_t b,
                                    logic we, reg_addr_t addr);
        exp_t        e;
        int          sh;
        word_t       lg;
        word_t       sf;
        word_t       ar;
        word_t       mv;
        word_t       nb;
        word_t       hi_cur;
        word_t       lo_cur;
        logic        ovf;
        logic [63:0] ext;
        logic [63:0] prod;
        e = '0;
        sh = int'(a[4:0]);
        lg = '0;
        sf = '0;
        ar = '0;
        mv = '0;
        ovf = 1'b0;
        prod = '0;
        hi_cur = mem_hi_we ? mem_hi_wdata : (wb_hi_we ? wb_hi_wdata : wb_hi_rdata);
        lo_cur = mem_lo_we ? mem_lo_wdata : (wb_lo_we ? wb_lo_wdata : wb_lo_rdata);
        case (op)
            OP_AND: lg = a & b;
            OP_OR:  lg = a | b;
            OP_XOR: lg = a ^ b;
            OP_NOR: lg = ~(a | b);
            OP_SLL: sf = b << sh;
            OP_SRL: sf = b >> sh;
            OP_SRA: begin
                ext = {{32{b[31]}}, b} >> sh;
                sf = ext[31:0];
            end
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                nb = (op == OP_SUB || op == OP_SUBU) ? -b : b;
                ar = a + nb;
                ovf = (op == OP_ADD || op == OP_SUB) && (a[31] == nb[31]) && (ar[31] != a[31]);
            end
            OP_SLT:  ar = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: ar = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ:  ar = word_t'(lead_count(a, 1'b0));
            OP_CLO:  ar = word_t'(lead_count(a, 1'b1));
            OP_MULT:  prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            OP_MULTU: prod = {32'd0, a} * {32'd0, b};
            OP_MFHI: mv = hi_cur;
            OP_MFLO: mv = lo_cur;
            default: begin
            end
        endcase
        case (cat)
            CAT_LOGIC: e.reg_data = lg;
            CAT_SHIFT: e.reg_data = sf;
            CAT_MOVE:  e.reg_data = mv;
            CAT_ARITH: e.reg_data = ar;
            default:   e.reg_data = '0;
        endcase
        e.reg_we = we && !ovf;
        e.reg_addr = addr;
        if (op == OP_MULT || op == OP_MULTU) begin
            e.hi_we = 1'b1;
            e.hi_data = prod[63:32];
            e.lo_we = 1'b1;
            e.lo_data = prod[31:0];
        end else if (op == OP_MTHI) begin
            e.hi_we = 1'b1;
            e.hi_data = a;
        end else if (op == OP_MTLO) begin
            e.lo_we = 1'b1;
            e.lo_data = a;
        end
        return e;
    endfunction

    function automatic word_t rand_word();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hFFFF_FFFF;
            2:       return 32'h7FFF_FFFF;
            3:       return 32'h8000_0000 | word_t'($urandom_range(0, 255));
            4:       return word_t'($urandom_range(0, 63));
            default: return $urandom;
        endcase
    endfunction

    task automatic clear_inputs();
        operator = OP_NOP;
        category = CAT_NONE;
        operand_a = '0;
        operand_b = '0;
        reg_write_en = 1'b0;
        reg_write_addr = '0;
        {mem_hi_we, wb_hi_we, mem_lo_we, wb_lo_we} = 4'b0000;
        mem_hi_wdata = '0;
        mem_lo_wdata = '0;
        wb_hi_wdata = '0;
        wb_lo_wdata = '0;
        wb_hi_rdata = '0;
        wb_lo_rdata = '0;
    endtask

    // fwd_en order is mem_hi, wb_hi, mem_lo, wb_lo
    task automatic load_inputs(op_t op, cat_t cat, word_t a, word_t b, logic we,
                               reg_addr_t addr, logic [3:0] fwd_en);
        operator = op;
        category = cat;
        operand_a = a;
        operand_b = b;
        reg_write_en = we;
        reg_write_addr = addr;
        {mem_hi_we, wb_hi_we, mem_lo_we, wb_lo_we} = fwd_en;
        mem_hi_wdata = $urandom;
        mem_lo_wdata = $urandom;
        wb_hi_wdata = $urandom;
        wb_lo_wdata = $urandom;
        wb_hi_rdata = $urandom;
        wb_lo_rdata = $urandom;
    endtask

    task automatic issue(op_t op, cat_t cat, word_t a, word_t b, logic we, logic [3:0] fwd_en);
        reg_addr_t addr;
        addr = reg_addr_t'($urandom);
        @(negedge clk);
        load_inputs(op, cat, a, b, we, addr, fwd_en);
        exp_q.push_back(ref_ex(op, cat, a, b, we, addr));
    endtask

    task automatic run_op(op_t op, word_t a, word_t b);
        issue(op, cat_of(op), a, b, 1'b1, 4'($urandom));
    endtask

    task automatic issue_random();
        op_t  op;
        cat_t cat;
        op = op_list[$urandom_range(0, 21)];
        cat = ($urandom_range(0, 3) == 0) ? cat_t'($urandom) : cat_of(op);
        issue(op, cat, rand_word(), rand_word(), ($urandom_range(0, 7) != 0), 4'($urandom));
    endtask

    task automatic check_outputs(exp_t e);
        check_val("reg_write_en_o", 64'(reg_we_out), 64'(e.reg_we));
        check_val("reg_write_addr_o", 64'(reg_addr_out), 64'(e.reg_addr));
        check_val("reg_write_data_o", 64'(reg_data_out), 64'(e.reg_data));
        check_val("hi_write_en_o", 64'(hi_we_out), 64'(e.hi_we));
        check_val("hi_write_data_o", 64'(hi_data_out), 64'(e.hi_data));
        check_val("lo_write_en_o", 64'(lo_we_out), 64'(e.lo_we));
        check_val("lo_write_data_o", 64'(lo_data_out), 64'(e.lo_data));
    endtask

    task automatic check_zero();
        check_outputs('0);
    endtask

    // One cycle of latency: ops seen at a rising edge are compared at the next falling edge
    initial begin : compare_proc
        int   pending;
        logic started;
        exp_t e;
        started = 1'b0;
        forever begin
            @(posedge clk);
            pending = exp_q.size();
            @(negedge clk);
            if (!arst_n || (!started && pending == 0)) begin
                check_zero();
            end else if (pending > 0) begin
                e = exp_q.pop_front();
                started = 1'b1;
                check_outputs(e);
            end
        end
    end

    initial begin : stimulus
        int guard;
        void'($urandom(32'h245c));
        clear_inputs();

        // Busy inputs during reset must not reach the outputs
        guard = 0;
        do begin
            @(negedge clk);
            guard++;
            if (guard > RESET_TIMEOUT) begin
                fail_run("timeout: reset was never released");
            end
            if (!arst_n) begin
                load_inputs(op_list[$urandom_range(1, 21)], 3'($urandom), $urandom, $urandom,
                            1'b1, reg_addr_t'($urandom), 4'($urandom));
            end
        end while (!arst_n);
        clear_inputs();

        foreach (op_list[i]) begin
            if (cat_of(op_list[i]) == CAT_LOGIC) begin
                run_op(op_list[i], rand_word(), rand_word());
            end
        end
        foreach (shamts[i]) begin
            run_op(OP_SLL, shamts[i], 32'h8000_1235);
            run_op(OP_SRL, shamts[i], 32'h8000_1235);
            run_op(OP_SRA, shamts[i], 32'h8000_1235);
            run_op(OP_SRA, shamts[i], 32'h4000_1235);
        end

        // Overflow cases, then the unsigned forms of the same operands
        run_op(OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
        run_op(OP_ADDU, 32'h7FFF_FFFF, 32'h0000_0001);
        run_op(OP_ADD, 32'h8000_0000, 32'hFFFF_FFFF);
        run_op(OP_ADDU, 32'h8000_0000, 32'hFFFF_FFFF);
        run_op(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        run_op(OP_SUBU, 32'h8000_0000, 32'h0000_0001);
        run_op(OP_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
        run_op(OP_SUBU, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
        run_op(OP_SLT, 32'hFFFF_FFFF, 32'h0000_0001);
        run_op(OP_SLTU, 32'hFFFF_FFFF, 32'h0000_0001);
        run_op(OP_SLT, 32'h0000_0001, 32'hFFFF_FFFF);
        run_op(OP_SLTU, 32'h0000_0001, 32'hFFFF_FFFF);
        run_op(OP_SLT, 32'h0000_0005, 32'h0000_0005);

        run_op(OP_CLZ, 32'h0000_0000, 32'h0);
        run_op(OP_CLZ, 32'hFFFF_FFFF, 32'h0);
        run_op(OP_CLO, 32'hFFFF_FFFF, 32'h0);
        run_op(OP_CLO, 32'h0000_0000, 32'h0);
        for (int k = 0; k < XLEN; k++) begin
            run_op(OP_CLZ, 32'h1 << k, rand_word());
            run_op(OP_CLO, ~(32'h1 << k), rand_word());
        end

        run_op(OP_MULT, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_op(OP_MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_op(OP_MULT, 32'h8000_0000, 32'h0000_0002);
        run_op(OP_MULTU, 32'h8000_0000, 32'h0000_0002);
        run_op(OP_MULT, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
        run_op(OP_MULT, rand_word(), rand_word());
        run_op(OP_MTHI, rand_word(), rand_word());
        run_op(OP_MTLO, rand_word(), rand_word());

        for (int en = 0; en < 16; en++) begin
            issue(OP_MFHI, CAT_MOVE, rand_word(), rand_word(), 1'b1, 4'(en));
            issue(OP_MFLO, CAT_MOVE, rand_word(), rand_word(), 1'b1, 4'(en));
        end

        repeat (NUM_RANDOM) begin
            issue_random();
        end

        guard = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            guard++;
            if (guard > DRAIN_TIMEOUT) begin
                fail_run("timeout: expected results were never compared");
            end
        end

        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/mips_isa_pkg.sv
hw/ex_types_pkg.sv
hw/ex_logic_shift.sv
hw/ex_arith.sv
hw/ex_hilo.sv
hw/ex_pipe_reg.sv
hw/ex_stage.sv
sim/tb_clk_gen.sv
sim/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ex_stage
FILELIST  := tb.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
